//--- Makefile
VERILATOR ?= verilator
TOP       ?= xbar_tb
FLIST     ?= xbar_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/xbar_tb.sv
`timescale 1ns/1ns

module xbar_tb;

  localparam int SRAM_AW = 11;
  localparam int TIMEOUT = 50;

  logic              clock;
  logic              rst_n;
  xbar_pkg::rd_req_t rd_req;
  xbar_pkg::rd_rsp_t rd_rsp;
  xbar_pkg::wr_req_t wr_req;
  xbar_pkg::wr_rsp_t wr_rsp;
  logic              diff_skip;
  logic              uart_tx_valid;
  logic [7:0]        uart_tx_byte;
  logic              ar_fire, aw_fire, thr_fire;
  longint unsigned   cycles;
  int                tx_count = 0;
  logic [7:0]        tx_seen;
  xbar_pkg::data_t   model [int unsigned];  // sram words the bench has written.

  xbar_top #(.SRAM_AW(SRAM_AW)) UUT (
    .clock         (clock),
    .rst_n         (rst_n),
    .rd_req        (rd_req),
    .rd_rsp        (rd_rsp),
    .wr_req        (wr_req),
    .wr_rsp        (wr_rsp),
    .diff_skip     (diff_skip),
    .uart_tx_valid (uart_tx_valid),
    .uart_tx_byte  (uart_tx_byte)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  assign ar_fire = rd_req.arvalid && rd_rsp.arready;
  assign aw_fire = wr_req.awvalid && wr_req.wvalid && wr_rsp.awready && wr_rsp.wready;
  assign thr_fire = aw_fire && wr_req.awaddr == xbar_pkg::UART_BASE && wr_req.wstrb[0];

  // counts the same clocks as mtime.
  always @(posedge clock) begin
    if (!rst_n) cycles <= 64'd0;
    else cycles <= cycles + 64'd1;
  end

  always @(negedge clock) begin
    if (rst_n && uart_tx_valid) begin
      tx_count = tx_count + 1;
      tx_seen = uart_tx_byte;
    end
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  function automatic logic expect_skip(input xbar_pkg::rd_req_t rq, input xbar_pkg::wr_req_t wq);
    logic rd_dev;
    logic wr_dev;
    rd_dev = (rq.araddr >= xbar_pkg::UART_BASE &&
              rq.araddr < xbar_pkg::UART_BASE + xbar_pkg::UART_SIZE) ||
             rq.araddr == xbar_pkg::CLINT_MTIME || rq.araddr == xbar_pkg::CLINT_MTIME + 32'd4;
    wr_dev = wq.awaddr >= xbar_pkg::UART_BASE &&
             wq.awaddr < xbar_pkg::UART_BASE + xbar_pkg::UART_SIZE;
    return (rq.arvalid && rd_dev) || (wq.awvalid && wr_dev);
  endfunction

  function automatic xbar_pkg::data_t merge_lanes(input xbar_pkg::data_t old_d,
                                                  input xbar_pkg::data_t new_d,
                                                  input xbar_pkg::strb_t strb);
    xbar_pkg::data_t res;
    res = old_d;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = new_d[8*i +: 8];
    end
    return res;
  endfunction

  assert property (@(posedge clock) disable iff (!rst_n) ar_fire |=> rd_rsp.rvalid)
    else stop_with_error($sformatf("Error at %0t: rd_rsp.rvalid expected 1, got 0", $time));
  assert property (@(posedge clock) disable iff (!rst_n) aw_fire |=> wr_rsp.bvalid)
    else stop_with_error($sformatf("Error at %0t: wr_rsp.bvalid expected 1, got 0", $time));
  assert property (@(posedge clock) disable iff (!rst_n)
    rd_rsp.rvalid && !rd_req.rready |=>
      rd_rsp.rvalid && $stable(rd_rsp.rdata) && $stable(rd_rsp.rresp))
    else stop_with_error("read response changed or dropped while rready was low");
  assert property (@(posedge clock) disable iff (!rst_n)
    wr_rsp.bvalid && !wr_req.bready |=> wr_rsp.bvalid && $stable(wr_rsp.bresp))
    else stop_with_error("write response changed or dropped while bready was low");
  assert property (@(posedge clock) disable iff (!rst_n) rd_rsp.rvalid |-> !rd_rsp.arready)
    else stop_with_error("read address accepted while a read response was outstanding");
  assert property (@(posedge clock) disable iff (!rst_n) wr_rsp.bvalid |-> !wr_rsp.awready)
    else stop_with_error("write address accepted while a write response was outstanding");
  assert property (@(posedge clock) disable iff (!rst_n)
    thr_fire |=> uart_tx_valid && uart_tx_byte == $past(wr_req.wdata[7:0]))
    else stop_with_error("uart tx strobe missing or wrong byte one cycle after the write");
  assert property (@(posedge clock) disable iff (!rst_n) uart_tx_valid |-> $past(thr_fire))
    else stop_with_error("uart tx strobe without a preceding uart data write");
  assert property (@(posedge clock) disable iff (!rst_n)
    diff_skip == expect_skip(rd_req, wr_req))
    else stop_with_error($sformatf("Error at %0t: diff_skip expected %b, got %b", $time,
                                   expect_skip(rd_req, wr_req), diff_skip));

  task automatic bus_read(input xbar_pkg::addr_t addr, output xbar_pkg::data_t data,
                          output xbar_pkg::resp_t resp);
    int n;
    int hold;
    hold = $urandom_range(8, 1);
    rd_req.arvalid = 1'b1;
    rd_req.araddr = addr;
    n = 0;
    do begin
      @(negedge clock);
      n++;
      if (n > TIMEOUT) stop_with_error("read address was never accepted");
    end while (!rd_rsp.arready);
    @(posedge clock);
    #1;
    rd_req.arvalid = 1'b0;
    n = 0;
    do begin
      @(negedge clock);
      n++;
      if (n > TIMEOUT) stop_with_error("read response never arrived");
    end while (!rd_rsp.rvalid);
    repeat (hold) @(posedge clock);  // back-pressure on the r channel.
    #1;
    rd_req.rready = 1'b1;
    @(negedge clock);
    data = rd_rsp.rdata;
    resp = rd_rsp.rresp;
    @(posedge clock);
    #1;
    rd_req.rready = 1'b0;
  endtask

  task automatic bus_write(input xbar_pkg::addr_t addr, input xbar_pkg::data_t data,
                           input xbar_pkg::strb_t strb, output xbar_pkg::resp_t resp);
    int n;
    int hold;
    hold = $urandom_range(8, 1);
    wr_req.awvalid = 1'b1;
    wr_req.awaddr = addr;
    wr_req.wvalid = 1'b1;
    wr_req.wdata = data;
    wr_req.wstrb = strb;
    n = 0;
    do begin
      @(negedge clock);
      n++;
      if (n > TIMEOUT) stop_with_error("write address and data were never accepted");
    end while (!(wr_rsp.awready && wr_rsp.wready));
    @(posedge clock);
    #1;
    wr_req.awvalid = 1'b0;
    wr_req.wvalid = 1'b0;
    n = 0;
    do begin
      @(negedge clock);
      n++;
      if (n > TIMEOUT) stop_with_error("write response never arrived");
    end while (!wr_rsp.bvalid);
    repeat (hold) @(posedge clock);
    #1;
    wr_req.bready = 1'b1;
    @(negedge clock);
    resp = wr_rsp.bresp;
    @(posedge clock);
    #1;
    wr_req.bready = 1'b0;
  endtask

  task automatic check_read(input xbar_pkg::addr_t addr, input xbar_pkg::data_t exp_data,
                            input xbar_pkg::resp_t exp_resp);
    xbar_pkg::data_t data;
    xbar_pkg::resp_t resp;
    bus_read(addr, data, resp);
    assert (resp == exp_resp) else stop_with_error($sformatf(
      "Error at %0t: rresp @%h expected %0d, got %0d", $time, addr, exp_resp, resp));
    assert (data == exp_data) else stop_with_error($sformatf(
      "Error at %0t: rdata @%h expected %h, got %h", $time, addr, exp_data, data));
  endtask

  task automatic read_okay(input xbar_pkg::addr_t addr, output xbar_pkg::data_t data);
    xbar_pkg::resp_t resp;
    bus_read(addr, data, resp);
    assert (resp == xbar_pkg::RESP_OKAY) else stop_with_error($sformatf(
      "Error at %0t: rresp @%h expected %0d, got %0d", $time, addr,
      xbar_pkg::RESP_OKAY, resp));
  endtask

  task automatic check_write(input xbar_pkg::addr_t addr, input xbar_pkg::data_t data,
                             input xbar_pkg::strb_t strb, input xbar_pkg::resp_t exp_resp);
    xbar_pkg::resp_t resp;
    bus_write(addr, data, strb, resp);
    assert (resp == exp_resp) else stop_with_error($sformatf(
      "Error at %0t: bresp @%h expected %0d, got %0d", $time, addr, exp_resp, resp));
  endtask

  task automatic sram_write(input int unsigned idx, input xbar_pkg::data_t data,
                            input xbar_pkg::strb_t strb);
    check_write(xbar_pkg::SRAM_BASE + (idx << 2), data, strb, xbar_pkg::RESP_OKAY);
    model[idx] = merge_lanes(model.exists(idx) ? model[idx] : '0, data, strb);
  endtask

  initial begin
    xbar_pkg::data_t d0, d1, hi;
    xbar_pkg::addr_t sram_end;
    int unsigned     idx;
    int              tx_before;
    void'($urandom(24));
    rst_n = 1'b0;
    rd_req = '0;
    wr_req = '0;
    repeat (10) @(posedge clock);
    #1;
    rst_n = 1'b1;
    @(negedge clock);
    assert (rd_rsp.arready && !rd_rsp.rvalid && wr_rsp.awready && wr_rsp.wready &&
            !wr_rsp.bvalid && !uart_tx_valid)
      else stop_with_error("handshake outputs not in their idle state after reset");
    @(posedge clock);
    #1;

    // every sram word gets a full write before its strobed updates.
    sram_write(0, $urandom, 4'hf);
    for (int i = 0; i < 40; i++) begin
      idx = $urandom_range(2**SRAM_AW - 1, 0);
      if (!model.exists(idx)) sram_write(idx, $urandom, 4'hf);
      sram_write(idx, $urandom, xbar_pkg::strb_t'($urandom_range(15, 0)));
      check_read(xbar_pkg::SRAM_BASE + (idx << 2), model[idx], xbar_pkg::RESP_OKAY);
    end

    read_okay(xbar_pkg::CLINT_MTIME, d0);
    read_okay(xbar_pkg::CLINT_MTIME, d1);
    assert (d1 > d0) else stop_with_error($sformatf(
      "Error at %0t: mtime low expected above %h, got %h", $time, d0, d1));
    read_okay(xbar_pkg::CLINT_MTIME + 32'd4, hi);
    assert ({hi, d1} <= cycles) else stop_with_error($sformatf(
      "Error at %0t: mtime expected at most %0d, got %0d", $time, cycles, {hi, d1}));
    check_write(xbar_pkg::CLINT_MTIME, $urandom, 4'hf, xbar_pkg::RESP_DECERR);

    tx_before = tx_count;
    d0 = $urandom;
    check_write(xbar_pkg::UART_BASE, d0, 4'b0001, xbar_pkg::RESP_OKAY);
    assert (tx_count == tx_before + 1) else stop_with_error($sformatf(
      "Error at %0t: uart_tx_valid pulses expected 1, got %0d", $time, tx_count - tx_before));
    assert (tx_seen == d0[7:0]) else stop_with_error($sformatf(
      "Error at %0t: uart_tx_byte expected %h, got %h", $time, d0[7:0], tx_seen));
    check_read(xbar_pkg::UART_BASE + xbar_pkg::UART_LSR_OFFSET, xbar_pkg::UART_LSR_IDLE,
               xbar_pkg::RESP_OKAY);

    // nothing in unmapped space may reach a subordinate.
    tx_before = tx_count;
    sram_end = xbar_pkg::SRAM_BASE + (32'd4 << SRAM_AW);
    check_write(32'h3000_0000, $urandom, 4'hf, xbar_pkg::RESP_DECERR);
    check_read(32'h3000_0000, '0, xbar_pkg::RESP_DECERR);
    check_write(sram_end, $urandom, 4'hf, xbar_pkg::RESP_DECERR);
    check_read(sram_end, '0, xbar_pkg::RESP_DECERR);
    check_write(xbar_pkg::UART_BASE + xbar_pkg::UART_SIZE, $urandom, 4'hf,
                xbar_pkg::RESP_DECERR);
    check_read(xbar_pkg::SRAM_BASE, model[0], xbar_pkg::RESP_OKAY);
    assert (tx_count == tx_before) else stop_with_error($sformatf(
      "Error at %0t: uart_tx_valid pulses expected 0, got %0d", $time, tx_count - tx_before));

    foreach (model[k]) check_read(xbar_pkg::SRAM_BASE + (k << 2), model[k], xbar_pkg::RESP_OKAY);

    $display("TEST OK");
    $finish;
  end

endmodule

//--- hw/axi_xbar.sv
`timescale 1ns/1ns

module axi_xbar #(
  parameter int SRAM_AW = 11
) (
  input  logic              clock,
  input  logic              rst_n,
  input  xbar_pkg::rd_req_t up_rd_req,
  output xbar_pkg::rd_rsp_t up_rd_rsp,
  input  xbar_pkg::wr_req_t up_wr_req,
  output xbar_pkg::wr_rsp_t up_wr_rsp,
  output xbar_pkg::rd_req_t sram_rd_req,
  input  xbar_pkg::rd_rsp_t sram_rd_rsp,
  output xbar_pkg::wr_req_t sram_wr_req,
  input  xbar_pkg::wr_rsp_t sram_wr_rsp,
  output xbar_pkg::rd_req_t clint_rd_req,
  input  xbar_pkg::rd_rsp_t clint_rd_rsp,
  output xbar_pkg::rd_req_t uart_rd_req,
  input  xbar_pkg::rd_rsp_t uart_rd_rsp,
  output xbar_pkg::wr_req_t uart_wr_req,
  input  xbar_pkg::wr_rsp_t uart_wr_rsp,
  output logic              diff_skip
);

  localparam xbar_pkg::addr_t SRAM_END =
    xbar_pkg::SRAM_BASE + (xbar_pkg::addr_t'(4) << SRAM_AW);

  xbar_pkg::rd_state_e rd_state;
  xbar_pkg::wr_state_e wr_state;
  xbar_pkg::zone_e     rd_zone_dec, rd_zone_q, rd_zone;
  xbar_pkg::zone_e     wr_zone_dec, wr_zone_q, wr_zone;
  xbar_pkg::rd_req_t   rd_fwd;
  xbar_pkg::rd_rsp_t   rd_sel;
  xbar_pkg::wr_req_t   wr_fwd;
  xbar_pkg::wr_rsp_t   wr_sel;
  logic                rd_addr_fire, rd_resp_fire;
  logic                wr_addr_fire, wr_resp_fire;

  // the timer is read only, so writes never land there.
  function automatic xbar_pkg::zone_e decode(input xbar_pkg::addr_t addr,
                                             input logic is_read);
    xbar_pkg::zone_e zone;
    zone = xbar_pkg::ZONE_NONE;
    if (addr >= xbar_pkg::UART_BASE && addr < xbar_pkg::UART_BASE + xbar_pkg::UART_SIZE) begin
      zone = xbar_pkg::ZONE_UART;
    end else if (is_read && (addr == xbar_pkg::CLINT_MTIME ||
                             addr == xbar_pkg::CLINT_MTIME + 32'd4)) begin
      zone = xbar_pkg::ZONE_CLINT;
    end else if (addr >= xbar_pkg::SRAM_BASE && addr < SRAM_END) begin
      zone = xbar_pkg::ZONE_SRAM;
    end
    return zone;
  endfunction

  assign rd_zone_dec = decode(up_rd_req.araddr, 1'b1);
  assign wr_zone_dec = decode(up_wr_req.awaddr, 1'b0);

  // live decode while idle, latched zone while a response is due.
  assign rd_zone = (rd_state == xbar_pkg::RD_IDLE) ? rd_zone_dec : rd_zone_q;
  assign wr_zone = (wr_state == xbar_pkg::WR_IDLE) ? wr_zone_dec : wr_zone_q;

  assign diff_skip = (up_rd_req.arvalid && (rd_zone_dec == xbar_pkg::ZONE_UART ||
                                            rd_zone_dec == xbar_pkg::ZONE_CLINT)) ||
                     (up_wr_req.awvalid && wr_zone_dec == xbar_pkg::ZONE_UART);

  always_comb begin
    rd_fwd = up_rd_req;
    rd_fwd.arvalid = up_rd_req.arvalid && rd_state == xbar_pkg::RD_IDLE;
    rd_fwd.rready = up_rd_req.rready && rd_state == xbar_pkg::RD_WAIT;
    sram_rd_req = '0;
    clint_rd_req = '0;
    uart_rd_req = '0;
    // unmapped target, answered here.
    rd_sel.arready = 1'b1;
    rd_sel.rvalid = 1'b1;
    rd_sel.rdata = '0;
    rd_sel.rresp = xbar_pkg::RESP_DECERR;
    case (rd_zone)
      xbar_pkg::ZONE_SRAM: begin
        sram_rd_req = rd_fwd;
        rd_sel = sram_rd_rsp;
      end
      xbar_pkg::ZONE_CLINT: begin
        clint_rd_req = rd_fwd;
        rd_sel = clint_rd_rsp;
      end
      xbar_pkg::ZONE_UART: begin
        uart_rd_req = rd_fwd;
        rd_sel = uart_rd_rsp;
      end
      default: ;
    endcase
    up_rd_rsp.arready = rd_sel.arready && rd_state == xbar_pkg::RD_IDLE;
    up_rd_rsp.rvalid = rd_sel.rvalid && rd_state == xbar_pkg::RD_WAIT;
    up_rd_rsp.rdata = rd_sel.rdata;
    up_rd_rsp.rresp = rd_sel.rresp;
  end

  always_comb begin
    wr_fwd = up_wr_req;
    wr_fwd.awvalid = up_wr_req.awvalid && wr_state == xbar_pkg::WR_IDLE;
    wr_fwd.wvalid = up_wr_req.wvalid && wr_state == xbar_pkg::WR_IDLE;
    wr_fwd.bready = up_wr_req.bready && wr_state == xbar_pkg::WR_WAIT;
    sram_wr_req = '0;
    uart_wr_req = '0;
    wr_sel.awready = 1'b1;
    wr_sel.wready = 1'b1;
    wr_sel.bvalid = 1'b1;
    wr_sel.bresp = xbar_pkg::RESP_DECERR;
    case (wr_zone)
      xbar_pkg::ZONE_SRAM: begin
        sram_wr_req = wr_fwd;
        wr_sel = sram_wr_rsp;
      end
      xbar_pkg::ZONE_UART: begin
        uart_wr_req = wr_fwd;
        wr_sel = uart_wr_rsp;
      end
      default: ;
    endcase
    up_wr_rsp.awready = wr_sel.awready && wr_state == xbar_pkg::WR_IDLE;
    up_wr_rsp.wready = wr_sel.wready && wr_state == xbar_pkg::WR_IDLE;
    up_wr_rsp.bvalid = wr_sel.bvalid && wr_state == xbar_pkg::WR_WAIT;
    up_wr_rsp.bresp = wr_sel.bresp;
  end

  assign rd_addr_fire = up_rd_req.arvalid && up_rd_rsp.arready;
  assign rd_resp_fire = up_rd_rsp.rvalid && up_rd_req.rready;
  assign wr_addr_fire = up_wr_req.awvalid && up_wr_req.wvalid &&
                        up_wr_rsp.awready && up_wr_rsp.wready;
  assign wr_resp_fire = up_wr_rsp.bvalid && up_wr_req.bready;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      rd_state <= xbar_pkg::RD_IDLE;
      rd_zone_q <= xbar_pkg::ZONE_NONE;
    end else begin
      case (rd_state)
        xbar_pkg::RD_IDLE: begin
          if (rd_addr_fire) begin
            rd_state <= xbar_pkg::RD_WAIT;
            rd_zone_q <= rd_zone_dec;
          end
        end
        default: begin
          if (rd_resp_fire) rd_state <= xbar_pkg::RD_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      wr_state <= xbar_pkg::WR_IDLE;
      wr_zone_q <= xbar_pkg::ZONE_NONE;
    end else begin
      case (wr_state)
        xbar_pkg::WR_IDLE: begin
          if (wr_addr_fire) begin
            wr_state <= xbar_pkg::WR_WAIT;
            wr_zone_q <= wr_zone_dec;
          end
        end
        default: begin
          if (wr_resp_fire) wr_state <= xbar_pkg::WR_IDLE;
        end
      endcase
    end
  end

endmodule

//--- hw/clint_timer.sv
`timescale 1ns/1ns

module clint_timer (
  input  logic              clock,
  input  logic              rst_n,
  input  xbar_pkg::rd_req_t rd_req,
  output xbar_pkg::rd_rsp_t rd_rsp
);

  logic [63:0]     mtime;
  xbar_pkg::data_t rdata_q;
  logic            rvalid_q;
  logic            rd_fire;

  assign rd_fire = rd_req.arvalid && rd_rsp.arready;

  always_comb begin
    rd_rsp.arready = !rvalid_q;
    rd_rsp.rvalid = rvalid_q;
    rd_rsp.rdata = rdata_q;
    rd_rsp.rresp = xbar_pkg::RESP_OKAY;
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // bit 2 picks the upper word at CLINT_MTIME + 4.
  always_ff @(posedge clock) begin
    if (rd_fire) rdata_q <= rd_req.araddr[2] ? mtime[63:32] : mtime[31:0];
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
    end else if (rd_req.rready) begin
      rvalid_q <= 1'b0;
    end
  end

endmodule

//--- hw/sram_slave.sv
`timescale 1ns/1ns

module sram_slave #(
  parameter int SRAM_AW = 11
) (
  input  logic              clock,
  input  logic              rst_n,
  input  xbar_pkg::rd_req_t rd_req,
  output xbar_pkg::rd_rsp_t rd_rsp,
  input  xbar_pkg::wr_req_t wr_req,
  output xbar_pkg::wr_rsp_t wr_rsp
);

  xbar_pkg::data_t    mem [2**SRAM_AW];
  xbar_pkg::data_t    rdata_q;
  logic               rvalid_q, bvalid_q;
  logic [SRAM_AW-1:0] rd_idx, wr_idx;
  logic               rd_fire, wr_fire;

  // word index wraps at the array depth.
  assign rd_idx = rd_req.araddr[SRAM_AW+1:2];
  assign wr_idx = wr_req.awaddr[SRAM_AW+1:2];

  assign rd_fire = rd_req.arvalid && rd_rsp.arready;
  assign wr_fire = wr_req.awvalid && wr_req.wvalid && wr_rsp.awready && wr_rsp.wready;

  always_comb begin
    rd_rsp.arready = !rvalid_q;  // one read in flight.
    rd_rsp.rvalid = rvalid_q;
    rd_rsp.rdata = rdata_q;
    rd_rsp.rresp = xbar_pkg::RESP_OKAY;
    wr_rsp.awready = !bvalid_q;
    wr_rsp.wready = !bvalid_q;
    wr_rsp.bvalid = bvalid_q;
    wr_rsp.bresp = xbar_pkg::RESP_OKAY;
  end

  always_ff @(posedge clock) begin
    if (rd_fire) rdata_q <= mem[rd_idx];
    if (wr_fire) begin
      for (int i = 0; i < 4; i++) begin
        if (wr_req.wstrb[i]) mem[wr_idx][8*i +: 8] <= wr_req.wdata[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (rd_req.rready) begin
        rvalid_q <= 1'b0;
      end
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (wr_req.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

endmodule

//--- hw/uart_tx_slave.sv
`timescale 1ns/1ns

module uart_tx_slave (
  input  logic              clock,
  input  logic              rst_n,
  input  xbar_pkg::rd_req_t rd_req,
  output xbar_pkg::rd_rsp_t rd_rsp,
  input  xbar_pkg::wr_req_t wr_req,
  output xbar_pkg::wr_rsp_t wr_rsp,
  output logic              tx_valid,
  output logic [7:0]        tx_byte
);

  localparam int OFF_W = $clog2(xbar_pkg::UART_SIZE);

  xbar_pkg::data_t rdata_q;
  logic            rvalid_q, bvalid_q;
  logic            rd_fire, wr_fire, thr_write;

  assign rd_fire = rd_req.arvalid && rd_rsp.arready;
  assign wr_fire = wr_req.awvalid && wr_req.wvalid && wr_rsp.awready && wr_rsp.wready;
  // only the holding register at offset 0 takes data.
  assign thr_write = wr_fire && wr_req.awaddr[OFF_W-1:0] == '0 && wr_req.wstrb[0];

  always_comb begin
    rd_rsp.arready = !rvalid_q;
    rd_rsp.rvalid = rvalid_q;
    rd_rsp.rdata = rdata_q;
    rd_rsp.rresp = xbar_pkg::RESP_OKAY;
    wr_rsp.awready = !bvalid_q;
    wr_rsp.wready = !bvalid_q;
    wr_rsp.bvalid = bvalid_q;
    wr_rsp.bresp = xbar_pkg::RESP_OKAY;
  end

  always_ff @(posedge clock) begin
    if (rd_fire) begin
      if (rd_req.araddr[OFF_W-1:0] == xbar_pkg::UART_LSR_OFFSET[OFF_W-1:0]) begin
        rdata_q <= xbar_pkg::UART_LSR_IDLE;  // always ready to send.
      end else begin
        rdata_q <= '0;
      end
    end
    if (thr_write) tx_byte <= wr_req.wdata[7:0];
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
      tx_valid <= 1'b0;
    end else begin
      tx_valid <= thr_write;  // single cycle strobe.
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (rd_req.rready) begin
        rvalid_q <= 1'b0;
      end
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (wr_req.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

endmodule

//--- hw/xbar_pkg.sv
package xbar_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_DECERR = 2'b11;

  typedef enum logic [1:0] {
    ZONE_NONE,
    ZONE_SRAM,
    ZONE_CLINT,
    ZONE_UART
  } zone_e;

  // fixed address map.
  localparam addr_t SRAM_BASE   = 32'h0f00_0000;
  localparam addr_t CLINT_MTIME = 32'h2000_bff8;  // low word, high word at +4.
  localparam addr_t UART_BASE   = 32'h1000_0000;
  localparam addr_t UART_SIZE   = 32'h0000_1000;

  localparam addr_t UART_LSR_OFFSET = 32'd5;
  localparam data_t UART_LSR_IDLE   = 32'h0000_0060;  // thr empty, tx idle.

  typedef struct packed {
    logic  arvalid;
    addr_t araddr;
    logic  rready;
  } rd_req_t;

  typedef struct packed {
    logic  arready;
    logic  rvalid;
    data_t rdata;
    resp_t rresp;
  } rd_rsp_t;

  typedef struct packed {
    logic  awvalid;
    addr_t awaddr;
    logic  wvalid;
    data_t wdata;
    strb_t wstrb;
    logic  bready;
  } wr_req_t;

  typedef struct packed {
    logic  awready;
    logic  wready;
    logic  bvalid;
    resp_t bresp;
  } wr_rsp_t;

  typedef enum logic {RD_IDLE, RD_WAIT} rd_state_e;
  typedef enum logic {WR_IDLE, WR_WAIT} wr_state_e;

endpackage

//--- hw/xbar_top.sv
`timescale 1ns/1ns

module xbar_top #(
  parameter int SRAM_AW = 11
) (
  input  logic              clock,
  input  logic              rst_n,
  input  xbar_pkg::rd_req_t rd_req,
  output xbar_pkg::rd_rsp_t rd_rsp,
  input  xbar_pkg::wr_req_t wr_req,
  output xbar_pkg::wr_rsp_t wr_rsp,
  output logic              diff_skip,
  output logic              uart_tx_valid,
  output logic [7:0]        uart_tx_byte
);

  xbar_pkg::rd_req_t sram_rd_req, clint_rd_req, uart_rd_req;
  xbar_pkg::rd_rsp_t sram_rd_rsp, clint_rd_rsp, uart_rd_rsp;
  xbar_pkg::wr_req_t sram_wr_req, uart_wr_req;
  xbar_pkg::wr_rsp_t sram_wr_rsp, uart_wr_rsp;

  axi_xbar #(.SRAM_AW(SRAM_AW)) u_xbar (
    .clock        (clock),
    .rst_n        (rst_n),
    .up_rd_req    (rd_req),
    .up_rd_rsp    (rd_rsp),
    .up_wr_req    (wr_req),
    .up_wr_rsp    (wr_rsp),
    .sram_rd_req  (sram_rd_req),
    .sram_rd_rsp  (sram_rd_rsp),
    .sram_wr_req  (sram_wr_req),
    .sram_wr_rsp  (sram_wr_rsp),
    .clint_rd_req (clint_rd_req),
    .clint_rd_rsp (clint_rd_rsp),
    .uart_rd_req  (uart_rd_req),
    .uart_rd_rsp  (uart_rd_rsp),
    .uart_wr_req  (uart_wr_req),
    .uart_wr_rsp  (uart_wr_rsp),
    .diff_skip    (diff_skip)
  );

  sram_slave #(.SRAM_AW(SRAM_AW)) u_sram (
    .clock  (clock),
    .rst_n  (rst_n),
    .rd_req (sram_rd_req),
    .rd_rsp (sram_rd_rsp),
    .wr_req (sram_wr_req),
    .wr_rsp (sram_wr_rsp)
  );

  clint_timer u_clint (
    .clock  (clock),
    .rst_n  (rst_n),
    .rd_req (clint_rd_req),
    .rd_rsp (clint_rd_rsp)
  );

  uart_tx_slave u_uart (
    .clock    (clock),
    .rst_n    (rst_n),
    .rd_req   (uart_rd_req),
    .rd_rsp   (uart_rd_rsp),
    .wr_req   (uart_wr_req),
    .wr_rsp   (uart_wr_rsp),
    .tx_valid (uart_tx_valid),
    .tx_byte  (uart_tx_byte)
  );

endmodule

//--- xbar_top.f
hw/xbar_pkg.sv
hw/axi_xbar.sv
hw/sram_slave.sv
hw/clint_timer.sv
hw/uart_tx_slave.sv
hw/xbar_top.sv
bench/xbar_tb.sv
